//--- hw/uart_pkg.sv
package uart_pkg;

  // One data byte on the line or at the host side.
  typedef logic [7:0] uart_byte_t;

  // Bit-time counter wide enough for any clock to baud ratio.
  typedef logic [31:0] bit_count_t;

  // Position within a frame from start (0) to stop (9).
  typedef logic [3:0] bit_index_t;

  // Frame layout of 8N1.
  localparam bit_index_t DATA_BITS  = 4'd8; // Data bits per frame.
  localparam bit_index_t STOP_INDEX = 4'd9; // Stop bit position.

  // Received byte with its one-cycle valid strobe.
  typedef struct packed {
    uart_byte_t data;
    logic       valid;
  } uart_rx_word_t;

  // Receiver states.
  typedef enum logic [1:0] {
    rx_hunt       = 2'd0, // Waiting for a start bit.
    rx_start_half = 2'd1, // Moving to the middle of the start bit.
    rx_data       = 2'd2  // Sampling data, then waiting out stop.
  } rx_state_e;

  // Transmitter states.
  typedef enum logic {
    tx_wait = 1'b0, // Line idle high.
    tx_send = 1'b1  // Frame on the line.
  } tx_state_e;

endpackage

//--- hw/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
  parameter int CLOCK_RATE = 40000000,
  parameter int BAUD       = 115200
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    serial_i,
  output uart_pkg::uart_rx_word_t rx_word_o
);

  // Bit time in clock cycles and half of it for the start bit.
  localparam uart_pkg::bit_count_t BIT_TIME = uart_pkg::bit_count_t'(CLOCK_RATE / BAUD);
  localparam uart_pkg::bit_count_t HALF_BIT = BIT_TIME / 2;

  logic                 sync_meta_q;
  logic                 sync_line_q;
  uart_pkg::rx_state_e  state_q;
  uart_pkg::bit_count_t count_q;
  uart_pkg::bit_index_t index_q;
  uart_pkg::uart_byte_t shift_q;
  uart_pkg::uart_byte_t data_q;
  logic                 valid_q;
  logic                 count_done;
  logic                 sample_now;
  logic                 last_bit;

  assign count_done = (count_q == '0);
  assign last_bit   = (index_q == uart_pkg::DATA_BITS - 4'd1);

  // Middle of a data bit.
  assign sample_now = (state_q == uart_pkg::rx_data) && count_done &&
                      (index_q < uart_pkg::DATA_BITS);

  // Two-stage synchronizer that idles high like the line.
  always_ff @(posedge clk) begin
    if (reset) begin
      sync_meta_q <= 1'b1;
      sync_line_q <= 1'b1;
    end else begin
      sync_meta_q <= serial_i;
      sync_line_q <= sync_meta_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= uart_pkg::rx_hunt;
      count_q <= '0;
      index_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0; // Single-cycle strobe.
      case (state_q)
        uart_pkg::rx_hunt: begin
          if (!sync_line_q) begin // Start bit edge.
            count_q <= HALF_BIT - 1;
            index_q <= '0;
            state_q <= uart_pkg::rx_start_half;
          end
        end

        uart_pkg::rx_start_half: begin
          if (!count_done) begin
            count_q <= count_q - 1;
          end else begin
            count_q <= BIT_TIME - 1; // Now mid start bit.
            state_q <= uart_pkg::rx_data;
          end
        end

        uart_pkg::rx_data: begin
          if (!count_done) begin
            count_q <= count_q - 1;
          end else if (sample_now) begin
            count_q <= BIT_TIME - 1;
            index_q <= index_q + 4'd1;
            if (last_bit) begin
              valid_q <= 1'b1;
            end
          end else begin
            // Back to hunt at mid stop bit.
            state_q <= uart_pkg::rx_hunt;
          end
        end

        default: begin
          state_q <= uart_pkg::rx_hunt;
        end
      endcase
    end
  end

  // Data arrives LSB first, so shift in from the top.
  always_ff @(posedge clk) begin
    if (sample_now) begin
      shift_q <= {sync_line_q, shift_q[7:1]};
      if (last_bit) begin
        data_q <= {sync_line_q, shift_q[7:1]}; // Held until next byte.
      end
    end
  end

  assign rx_word_o.data  = data_q;
  assign rx_word_o.valid = valid_q;

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLOCK_RATE = 40000000,
  parameter int BAUD       = 115200
) (
  input  logic                 clk,
  input  logic                 reset,
  input  uart_pkg::uart_byte_t tx_data_i,
  input  logic                 tx_strobe_i,
  output logic                 serial_o,
  output logic                 tx_busy_o
);

  localparam uart_pkg::bit_count_t BIT_TIME = uart_pkg::bit_count_t'(CLOCK_RATE / BAUD);

  uart_pkg::tx_state_e  state_q;
  uart_pkg::bit_count_t count_q;
  uart_pkg::bit_index_t index_q;
  uart_pkg::uart_byte_t data_q;
  logic                 serial_q;
  logic                 accept;
  logic                 bit_end;

  // Line level for a given frame position.
  function automatic logic frame_level(uart_pkg::bit_index_t index,
                                       uart_pkg::uart_byte_t data);
    logic level;
    level = 1'b1; // Stop bit and idle.
    if (index == '0) begin
      level = 1'b0; // Start bit.
    end else if (index <= uart_pkg::DATA_BITS) begin
      level = data[3'(index - 4'd1)];
    end
    return level;
  endfunction

  // Strobes seen during a frame are dropped.
  assign accept  = (state_q == uart_pkg::tx_wait) && tx_strobe_i;
  assign bit_end = (count_q >= BIT_TIME - 1);

  assign serial_o  = serial_q;
  assign tx_busy_o = tx_strobe_i | (state_q == uart_pkg::tx_send);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= uart_pkg::tx_wait;
      count_q  <= '0;
      index_q  <= '0;
      serial_q <= 1'b1;
    end else begin
      case (state_q)
        uart_pkg::tx_wait: begin
          serial_q <= 1'b1;
          if (accept) begin
            count_q <= '0;
            index_q <= '0;
            state_q <= uart_pkg::tx_send;
          end
        end

        uart_pkg::tx_send: begin
          serial_q <= frame_level(index_q, data_q);
          if (!bit_end) begin
            count_q <= count_q + 1;
          end else if (index_q == uart_pkg::STOP_INDEX) begin
            state_q <= uart_pkg::tx_wait; // Frame done.
          end else begin
            count_q <= '0;
            index_q <= index_q + 4'd1;
          end
        end

        default: begin
          state_q <= uart_pkg::tx_wait;
        end
      endcase
    end
  end

  // Byte is held for the whole frame.
  always_ff @(posedge clk) begin
    if (accept) begin
      data_q <= tx_data_i;
    end
  end

endmodule

//--- hw/serial_uart.sv
`timescale 1ns/1ps

module serial_uart #(
  parameter int CLOCK_RATE = 40000000,
  parameter int BAUD       = 115200
) (
  input  logic                 clk,
  input  logic                 reset,

  // Serial line.
  input  logic                 serial_i,
  output logic                 serial_o,

  // Host side, transmit.
  input  uart_pkg::uart_byte_t tx_data_i,
  input  logic                 tx_strobe_i,
  output logic                 tx_busy_o,

  // Host side, receive.
  output uart_pkg::uart_byte_t rx_data_o,
  output logic                 rx_strobe_o
);

  uart_pkg::uart_rx_word_t rx_word;

  uart_rx #(
    .CLOCK_RATE (CLOCK_RATE),
    .BAUD       (BAUD)
  ) rx_i (
    .clk       (clk),
    .reset     (reset),
    .serial_i  (serial_i),
    .rx_word_o (rx_word)
  );

  uart_tx #(
    .CLOCK_RATE (CLOCK_RATE),
    .BAUD       (BAUD)
  ) tx_i (
    .clk         (clk),
    .reset       (reset),
    .tx_data_i   (tx_data_i),
    .tx_strobe_i (tx_strobe_i),
    .serial_o    (serial_o),
    .tx_busy_o   (tx_busy_o)
  );

  assign rx_data_o   = rx_word.data;
  assign rx_strobe_o = rx_word.valid;

endmodule

//--- sim/tb_serial_uart.sv
`timescale 1ns/1ps

module tb_serial_uart;

  localparam int          CLOCK_RATE     = 25000000;
  localparam int          BAUD           = 1562500;
  localparam int          CLK_PERIOD     = 40;
  localparam int          SETTLE_NS      = 5;
  localparam int          BIT_CYCLES     = 16;
  localparam int          FRAME_CYCLES   = 10 * BIT_CYCLES;
  localparam int          BUSY_CYCLES    = FRAME_CYCLES + 1; // Strobe cycle plus the frame.
  localparam int          POKE_CYCLE     = 40;
  localparam int          TX_LIMIT       = 400;
  localparam int          IDLE_LIMIT     = 200;
  localparam int          RANDOM_RECORDS = 16;
  localparam logic [15:0] LFSR_SEED      = 16'd22427;
  localparam logic [15:0] LFSR_TAPS      = 16'hB400;
  localparam string       STIM_FILE      = "sim/uart_stimulus.txt";

  logic                 clk;
  logic                 reset;
  logic                 serial_i;
  logic                 serial_o;
  uart_pkg::uart_byte_t tx_data_i;
  logic                 tx_strobe_i;
  logic                 tx_busy_o;
  uart_pkg::uart_byte_t rx_data_o;
  logic                 rx_strobe_o;

  int          errors;
  int          checks;
  logic [15:0] lfsr_state;

  serial_uart #(
    .CLOCK_RATE (CLOCK_RATE),
    .BAUD       (BAUD)
  ) dut_i (
    .clk         (clk),
    .reset       (reset),
    .serial_i    (serial_i),
    .serial_o    (serial_o),
    .tx_data_i   (tx_data_i),
    .tx_strobe_i (tx_strobe_i),
    .tx_busy_o   (tx_busy_o),
    .rx_data_o   (rx_data_o),
    .rx_strobe_o (rx_strobe_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Inputs change right at the falling edge.
  task automatic next_cycle();
    @(negedge clk);
  endtask

  task automatic settle();
    #(SETTLE_NS);
  endtask

  function automatic logic [15:0] lfsr_step(logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ LFSR_TAPS;
    end
    return next;
  endfunction

  task automatic random_bits(input int count, output logic [7:0] value);
    value = '0;
    for (int k = 0; k < count; k++) begin
      value      = {value[6:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic idle_cycles(input int count);
    for (int c = 0; c < count; c++) begin
      next_cycle();
      settle();
      check("no stray rx strobe", 32'(1'b0), 32'(rx_strobe_o));
    end
  endtask

  task automatic check_reset_state();
    for (int c = 0; c < 40; c++) begin
      next_cycle();
      settle();
      check("reset serial_o", 32'(1'b1), 32'(serial_o));
      check("reset tx_busy_o", 32'(1'b0), 32'(tx_busy_o));
      check("reset rx_strobe_o", 32'(1'b0), 32'(rx_strobe_o));
    end
  endtask

  // Sends one byte and watches the line and busy. A poke adds a strobe mid frame.
  task automatic send_frame(input string name, input uart_pkg::uart_byte_t data,
                            input bit poke);
    logic [9:0] frame;
    int         wait_c;
    int         first_low;
    int         busy_len;
    int         done_c;
    int         offset;
    bit         busy_done;
    frame     = {1'b1, data, 1'b0}; // Stop, data LSB first, start.
    first_low = -1;
    busy_len  = 0;
    done_c    = 0;
    busy_done = 1'b0;
    wait_c    = 0;
    while (tx_busy_o !== 1'b0 && wait_c < IDLE_LIMIT) begin
      next_cycle();
      settle();
      wait_c++;
    end
    if (tx_busy_o !== 1'b0) begin
      errors++;
      $display("timeout waiting for the transmitter to go idle before %s", name);
    end
    for (int c = 0; c < TX_LIMIT; c++) begin
      next_cycle();
      tx_strobe_i = (c == 0) || (poke && (c == POKE_CYCLE));
      if (c == 0) begin
        tx_data_i = data;
      end else if (poke && (c == POKE_CYCLE)) begin
        tx_data_i = ~data; // Must be ignored.
      end
      settle();
      if (c == 0) begin
        check($sformatf("%s busy in strobe cycle", name), 32'(1'b1), 32'(tx_busy_o));
      end
      if (!busy_done) begin
        if (tx_busy_o === 1'b1) begin
          busy_len++;
        end else begin
          busy_done = 1'b1;
          done_c    = c;
          check($sformatf("%s busy length", name), 32'(BUSY_CYCLES), 32'(busy_len));
        end
      end else begin
        check($sformatf("%s busy after frame", name), 32'(1'b0), 32'(tx_busy_o));
        check($sformatf("%s line after frame", name), 32'(1'b1), 32'(serial_o));
      end
      if (first_low < 0 && serial_o === 1'b0) begin
        first_low = c;
      end
      if (first_low >= 0) begin
        offset = c - first_low;
        if (offset < FRAME_CYCLES && (offset % BIT_CYCLES) == BIT_CYCLES / 2) begin
          check($sformatf("%s bit %0d", name, offset / BIT_CYCLES),
                32'(frame[4'(offset / BIT_CYCLES)]), 32'(serial_o));
        end
      end
      if (busy_done && (!poke || c >= done_c + 3 * BIT_CYCLES)) begin
        break;
      end
    end
    tx_strobe_i = 1'b0;
    if (first_low < 0) begin
      errors++;
      $display("serial_o never went low after the send strobe of %s", name);
    end
    if (!busy_done) begin
      errors++;
      $display("timeout waiting for tx_busy_o to fall after %s", name);
    end
  endtask

  // Drives one frame on serial_i and counts receive strobes meanwhile.
  task automatic receive_frame(input string name, input uart_pkg::uart_byte_t data);
    logic [9:0] frame;
    int         pulses;
    frame  = {1'b1, data, 1'b0};
    pulses = 0;
    for (int c = 0; c < FRAME_CYCLES; c++) begin
      next_cycle();
      serial_i = frame[4'(c / BIT_CYCLES)];
      settle();
      if (rx_strobe_o === 1'b1) begin
        pulses++;
        check($sformatf("%s data at strobe", name), 32'(data), 32'(rx_data_o));
      end
    end
    serial_i = 1'b1;
    check($sformatf("%s strobe count", name), 32'd1, 32'(pulses));
    check($sformatf("%s data held", name), 32'(data), 32'(rx_data_o));
  endtask

  task automatic run_stimulus_file();
    int                   fd;
    int                   code;
    int                   gap;
    int                   rec;
    logic [7:0]           dir;
    uart_pkg::uart_byte_t value;
    logic [8*128-1:0]     rest;
    rec = 0;
    fd  = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file %s", STIM_FILE);
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", dir);
        if (code != 1) begin
          break;
        end
        if (dir == "#") begin
          code = $fgets(rest, fd); // Comment line.
        end else begin
          code = $fscanf(fd, "%h %d", value, gap);
          if (code != 2) begin
            errors++;
            $display("record %0d of the stimulus file could not be parsed", rec);
            break;
          end
          idle_cycles(gap);
          if (dir == "t") begin
            send_frame($sformatf("file %0d send", rec), value, 1'b1);
          end else if (dir == "r") begin
            receive_frame($sformatf("file %0d receive", rec), value);
          end else begin
            errors++;
            $display("record %0d of the stimulus file has an unknown direction", rec);
          end
          rec++;
        end
      end
      $fclose(fd);
      if (rec == 0) begin
        errors++;
        $display("the stimulus file held no records");
      end
    end
  endtask

  initial begin
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    logic [7:0] gap_bits;
    serial_i    = 1'b1;
    tx_data_i   = '0;
    tx_strobe_i = 1'b0;
    reset       = 1'b1;
    errors      = 0;
    checks      = 0;
    lfsr_state  = LFSR_SEED;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_reset_state();
    run_stimulus_file();

    // Random bytes both ways at once with gaps of 0 to 3 bit times.
    for (int i = 0; i < RANDOM_RECORDS; i++) begin
      random_bits(8, tx_byte);
      random_bits(8, rx_byte);
      random_bits(2, gap_bits);
      idle_cycles(int'(gap_bits) * BIT_CYCLES);
      fork
        send_frame($sformatf("random %0d send", i), tx_byte, 1'b0);
        receive_frame($sformatf("random %0d receive", i), rx_byte);
      join
    end
    idle_cycles(40);

    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sim/uart_stimulus.txt
# Columns: direction (t send, r receive), byte in hex, idle cycles before the record.
# Receive records with a gap of 0 follow the previous frame back to back.
t a5 10
t 00 0
t ff 5
t 01 20
t 80 0
t 55 3
t aa 0
r a5 10
r 00 0
r ff 0
r 01 8
r 80 0
r 55 33
r aa 0
t 3c 16
r c3 0
t 7e 2
r 81 0
r 18 0
r e7 17
t 0f 0
t f0 1
r 69 4
r 96 0
t 12 40
r 34 0
t 56 9
r 78 0
r 9a 0
r bc 0
t de 31
t ef 0
r fe 12
r 7f 0
t 40 6
r 02 0
t fd 0
r bf 25

//--- project.f
hw/uart_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/serial_uart.sv
sim/tb_serial_uart.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_serial_uart
RTL_TOP    ?= serial_uart
FILELIST   ?= project.f
BUILD_DIR  ?= build
LOG        ?= sim.log
VFLAGS     ?= --timing
LINT_FLAGS ?= --lint-only
PASS_MSG   ?= Simulation completed successfully
FAIL_MSG   ?= Simulation failed

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter hw/%,$(SRCS))
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
